// File: verilog/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  localparam addr_t RESET_PC = 16'h0200;

  // Zero-page indexed sums wrap inside this width
  localparam int ZP_MASK_W = 8;

  // One memory read is REQ, WAIT, RECV
  typedef enum logic [1:0] {
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_RECV,
    EXECUTE
  } seq_state_t;

  // Which byte the current read returns
  typedef enum logic [2:0] {
    FETCH_OPCODE,
    FETCH_OPERAND_LO,
    FETCH_OPERAND_HI,
    FETCH_DATA
  } fetch_stage_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

  typedef enum logic [7:0] {
    OP_JMP_ABS  = 8'h4C,
    OP_LDA_IMM  = 8'hA9,
    OP_LDA_ZP   = 8'hA5,
    OP_LDA_ZPX  = 8'hB5,
    OP_LDA_ABS  = 8'hAD,
    OP_LDA_ABSX = 8'hBD,
    OP_LDA_ABSY = 8'hB9,
    OP_LDX_IMM  = 8'hA2,
    OP_LDX_ZP   = 8'hA6,
    OP_LDX_ZPY  = 8'hB6,
    OP_LDX_ABS  = 8'hAE,
    OP_LDX_ABSY = 8'hBE,
    OP_LDY_IMM  = 8'hA0,
    OP_LDY_ZP   = 8'hA4,
    OP_LDY_ZPX  = 8'hB4,
    OP_LDY_ABS  = 8'hAC,
    OP_LDY_ABSX = 8'hBC
  } opcode_t;

  typedef enum logic [2:0] {
    MODE_IMM,
    MODE_ZP,
    MODE_ZPX,
    MODE_ZPY,
    MODE_ABS,
    MODE_ABSX,
    MODE_ABSY,
    MODE_NONE  // No operand bytes, also unknown opcodes
  } addr_mode_t;

  typedef enum logic [1:0] {
    DEST_A,
    DEST_X,
    DEST_Y,
    DEST_PC
  } dest_reg_t;

endpackage

// File: verilog/opcode_decoder.sv
`timescale 1ns/10ps

module opcode_decoder (
  input  isa_pkg::opcode_t    opcode,
  output isa_pkg::addr_mode_t mode,
  output isa_pkg::dest_reg_t  dest,
  output logic [1:0]          length
);

  import isa_pkg::*;

  always_comb begin
    case (opcode)
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM:               mode = MODE_IMM;
      OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP:                  mode = MODE_ZP;
      OP_LDA_ZPX, OP_LDY_ZPX:                           mode = MODE_ZPX;
      OP_LDX_ZPY:                                       mode = MODE_ZPY;
      OP_JMP_ABS, OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS:   mode = MODE_ABS;
      OP_LDA_ABSX, OP_LDY_ABSX:                         mode = MODE_ABSX;
      OP_LDA_ABSY, OP_LDX_ABSY:                         mode = MODE_ABSY;
      default:                                          mode = MODE_NONE;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_LDX_IMM, OP_LDX_ZP, OP_LDX_ZPY, OP_LDX_ABS, OP_LDX_ABSY: dest = DEST_X;
      OP_LDY_IMM, OP_LDY_ZP, OP_LDY_ZPX, OP_LDY_ABS, OP_LDY_ABSX: dest = DEST_Y;
      OP_JMP_ABS:                                                  dest = DEST_PC;
      default:                                                     dest = DEST_A;
    endcase
  end

  // Instruction length follows from the operand size
  always_comb begin
    case (mode)
      MODE_NONE:                          length = 2'd1;
      MODE_ABS, MODE_ABSX, MODE_ABSY:     length = 2'd3;
      default:                            length = 2'd2;
    endcase
  end

endmodule

// File: verilog/addr_gen.sv
`timescale 1ns/10ps

module addr_gen (
  input  cpu_pkg::addr_t      operands,
  input  isa_pkg::addr_mode_t mode,
  input  cpu_pkg::data_t      x_reg,
  input  cpu_pkg::data_t      y_reg,
  output cpu_pkg::addr_t      data_addr
);

  import cpu_pkg::*;
  import isa_pkg::*;

  data_t                index;
  logic [ZP_MASK_W-1:0] zp_sum;
  addr_t                abs_sum;

  assign index   = (mode == MODE_ZPY || mode == MODE_ABSY) ? y_reg : x_reg;
  assign zp_sum  = operands[ZP_MASK_W-1:0] + index;  // Stays in page zero
  assign abs_sum = operands + addr_t'(index);

  always_comb begin
    case (mode)
      MODE_ZP:              data_addr = addr_t'(operands[ZP_MASK_W-1:0]);
      MODE_ZPX, MODE_ZPY:   data_addr = addr_t'(zp_sum);
      MODE_ABSX, MODE_ABSY: data_addr = abs_sum;
      default:              data_addr = operands;
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_en,
  input  isa_pkg::dest_reg_t dest,
  input  cpu_pkg::data_t     load_value,
  output cpu_pkg::data_t     a_out,
  output cpu_pkg::data_t     x_out,
  output cpu_pkg::data_t     y_out,
  output logic               flag_z,
  output logic               flag_n
);

  import cpu_pkg::*;
  import isa_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_out  <= '0;
      x_out  <= '0;
      y_out  <= '0;
      flag_z <= 1'b0;
      flag_n <= 1'b0;
    end else if (load_en && dest != DEST_PC) begin
      // Flags always follow the loaded register
      flag_z <= (load_value == '0);
      flag_n <= load_value[DATA_W-1];
      case (dest)
        DEST_X:  x_out <= load_value;
        DEST_Y:  y_out <= load_value;
        default: a_out <= load_value;
      endcase
    end
  end

endmodule

// File: verilog/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  output cpu_pkg::addr_t      mem_addr,
  output logic                mem_rd,
  input  cpu_pkg::data_t      mem_rdata,
  output isa_pkg::opcode_t    opcode,
  output cpu_pkg::addr_t      operands,
  input  isa_pkg::addr_mode_t mode,
  input  isa_pkg::dest_reg_t  dest,
  input  logic [1:0]          length,
  input  cpu_pkg::addr_t      data_addr,
  output logic                load_en,
  output cpu_pkg::data_t      load_value,
  output logic                retire,
  output cpu_pkg::addr_t      pc_out
);

  import cpu_pkg::*;
  import isa_pkg::*;

  seq_state_t   state;
  fetch_stage_t fetch_stage;
  addr_t        pc;
  addr_t        fetch_offset;
  opcode_t      opcode_q;
  data_t        data_byte;
  logic         opcode_recv;
  logic         needs_data;
  logic         exec_done;

  assign opcode_recv = (state == FETCH_RECV) && (fetch_stage == FETCH_OPCODE);

  // Decode the new opcode in the cycle it arrives
  assign opcode = opcode_recv ? opcode_t'(mem_rdata) : opcode_q;

  // Loads that read a data byte before they complete
  assign needs_data = (dest != DEST_PC) && (mode != MODE_IMM) && (mode != MODE_NONE);
  assign exec_done  = (state == EXECUTE) && (!needs_data || fetch_stage == FETCH_DATA);

  always_comb begin
    case (fetch_stage)
      FETCH_OPERAND_LO: fetch_offset = 16'd1;
      FETCH_OPERAND_HI: fetch_offset = 16'd2;
      default:          fetch_offset = 16'd0;
    endcase
  end

  assign mem_rd   = rst_n && (state == FETCH_REQ);  // Quiet while in reset
  assign mem_addr = (fetch_stage == FETCH_DATA) ? data_addr : pc + fetch_offset;

  assign load_en    = exec_done && (dest != DEST_PC) && (mode != MODE_NONE);
  assign load_value = (mode == MODE_IMM) ? operands[DATA_W-1:0] : data_byte;
  assign pc_out     = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= FETCH_REQ;
      fetch_stage <= FETCH_OPCODE;
      pc          <= RESET_PC;
      retire      <= 1'b0;
    end else begin
      retire <= exec_done;  // PC and registers are updated by then
      case (state)
        FETCH_REQ:  state <= FETCH_WAIT;
        FETCH_WAIT: state <= FETCH_RECV;
        FETCH_RECV: begin
          state <= FETCH_REQ;
          case (fetch_stage)
            FETCH_OPCODE: begin
              if (length == 2'd1) begin
                state <= EXECUTE;
              end else begin
                fetch_stage <= FETCH_OPERAND_LO;
              end
            end
            FETCH_OPERAND_LO: begin
              if (length == 2'd3) begin
                fetch_stage <= FETCH_OPERAND_HI;
              end else begin
                state <= EXECUTE;
              end
            end
            default: state <= EXECUTE;  // High byte or data byte
          endcase
        end
        EXECUTE: begin
          state <= FETCH_REQ;
          if (exec_done) begin
            fetch_stage <= FETCH_OPCODE;
            if (dest == DEST_PC) begin
              pc <= operands;
            end else begin
              pc <= pc + addr_t'(length);
            end
          end else begin
            fetch_stage <= FETCH_DATA;  // Issue the data read
          end
        end
        default: state <= FETCH_REQ;
      endcase
    end
  end

  // Opcode, operand and data bytes
  always_ff @(posedge clk) begin
    if (state == FETCH_RECV) begin
      case (fetch_stage)
        FETCH_OPCODE: begin
          opcode_q <= opcode_t'(mem_rdata);
          operands <= '0;
        end
        FETCH_OPERAND_LO: operands[7:0]  <= mem_rdata;
        FETCH_OPERAND_HI: operands[15:8] <= mem_rdata;
        default:          data_byte      <= mem_rdata;
      endcase
    end
  end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  output cpu_pkg::addr_t mem_addr,
  output logic           mem_rd,
  input  cpu_pkg::data_t mem_rdata,
  output logic           retire,
  output cpu_pkg::addr_t pc_out,
  output cpu_pkg::data_t a_out,
  output cpu_pkg::data_t x_out,
  output cpu_pkg::data_t y_out,
  output logic           flag_z,
  output logic           flag_n
);

  isa_pkg::opcode_t    opcode;
  isa_pkg::addr_mode_t mode;
  isa_pkg::dest_reg_t  dest;
  logic [1:0]          length;
  cpu_pkg::addr_t      operands;
  cpu_pkg::addr_t      data_addr;
  logic                load_en;
  cpu_pkg::data_t      load_value;

  cpu_sequencer seq_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_addr   (mem_addr),
    .mem_rd     (mem_rd),
    .mem_rdata  (mem_rdata),
    .opcode     (opcode),
    .operands   (operands),
    .mode       (mode),
    .dest       (dest),
    .length     (length),
    .data_addr  (data_addr),
    .load_en    (load_en),
    .load_value (load_value),
    .retire     (retire),
    .pc_out     (pc_out)
  );

  opcode_decoder dec_i (
    .opcode (opcode),
    .mode   (mode),
    .dest   (dest),
    .length (length)
  );

  // Index registers come straight from the register file
  addr_gen agen_i (
    .operands  (operands),
    .mode      (mode),
    .x_reg     (x_out),
    .y_reg     (y_out),
    .data_addr (data_addr)
  );

  reg_file regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .dest       (dest),
    .load_value (load_value),
    .a_out      (a_out),
    .x_out      (x_out),
    .y_out      (y_out),
    .flag_z     (flag_z),
    .flag_n     (flag_n)
  );

endmodule

// File: sim/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;

  import cpu_pkg::*;

  localparam int CLK_HALF        = 50;
  localparam int DRIVE_DLY       = 5;   // ns after the rising edge
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_INSN = 17;  // Absolute forms are the longest
  localparam int MARGIN          = 50;

  logic  clk       = 1'b0;
  logic  rst_n;
  addr_t mem_addr;
  logic  mem_rd;
  data_t mem_rdata = '0;
  logic  retire;
  addr_t pc_out;
  data_t a_out;
  data_t x_out;
  data_t y_out;
  logic  flag_z;
  logic  flag_n;

  // 64K memory model with unfilled bytes reading as zero
  data_t mem [0:65535] = '{default: '0};
  logic  read_req  = 1'b0;
  addr_t read_addr = '0;

  // Expected retire records in retire order
  addr_t exp_pc[$];
  data_t exp_a[$];
  data_t exp_x[$];
  data_t exp_y[$];
  logic  exp_z[$];
  logic  exp_n[$];

  int num_records = 0;
  int retired     = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  cpu_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_rd    (mem_rd),
    .mem_rdata (mem_rdata),
    .retire    (retire),
    .pc_out    (pc_out),
    .a_out     (a_out),
    .x_out     (x_out),
    .y_out     (y_out),
    .flag_z    (flag_z),
    .flag_n    (flag_n)
  );

  always #CLK_HALF clk = ~clk;

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic finish_run();
    $display("SIMULATION PASSED");
    $finish;
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_byte(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      fail_run();
    end
  endtask

  // Parses M memory lines, E retire records and # comments
  task automatic load_stim();
    int               fd;
    int               got;
    logic [7:0]       tag;
    addr_t            addr;
    data_t            value;
    addr_t            pc;
    data_t            a;
    data_t            x;
    data_t            y;
    logic             z;
    logic             n;
    logic [8*160-1:0] rest;
    fd = $fopen("sim/cpu_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stim file sim/cpu_stim.txt");
      fail_run();
    end
    while (!$feof(fd)) begin
      got = $fscanf(fd, " %c", tag);
      if (got != 1) break;
      case (tag)
        "#": got = $fgets(rest, fd);  // Rest of the line
        "M": begin
          got = $fscanf(fd, " %h %h", addr, value);
          if (got != 2) begin
            $display("a memory line in the stim file is malformed");
            fail_run();
          end
          mem[addr] = value;
        end
        "E": begin
          got = $fscanf(fd, " %h %h %h %h %h %h", pc, a, x, y, z, n);
          if (got != 6) begin
            $display("an expected record in the stim file is malformed");
            fail_run();
          end
          exp_pc.push_back(pc);
          exp_a.push_back(a);
          exp_x.push_back(x);
          exp_y.push_back(y);
          exp_z.push_back(z);
          exp_n.push_back(n);
        end
        default: begin
          $display("the stim file has a line with unknown tag %c", tag);
          fail_run();
        end
      endcase
    end
    $fclose(fd);
    num_records = exp_pc.size();
    if (num_records == 0) begin
      $display("the stim file holds no expected records");
      fail_run();
    end
  endtask

  // Request sampled mid-cycle and byte driven just after the next rising edge
  always @(negedge clk) begin
    if (mem_rd === 1'b1 && rst_n !== 1'b1) begin
      $display("memory read requested while reset is asserted");
      fail_run();
    end
    if (mem_rd === 1'b1 && read_req === 1'b1) begin
      $display("memory read request held high for more than one cycle");
      fail_run();
    end
    read_req  <= mem_rd;
    read_addr <= mem_addr;
  end

  always @(posedge clk) begin
    if (read_req) begin
      #DRIVE_DLY;
      mem_rdata = mem[read_addr];
    end
  end

  // Retire outputs are steady for the whole cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1 && retire === 1'b1) begin
      check_addr("pc_out", exp_pc.pop_front(), pc_out);
      check_byte("a_out", exp_a.pop_front(), a_out);
      check_byte("x_out", exp_x.pop_front(), x_out);
      check_byte("y_out", exp_y.pop_front(), y_out);
      check_flag("flag_z", exp_z.pop_front(), flag_z);
      check_flag("flag_n", exp_n.pop_front(), flag_n);
      retired++;
      if (retired == num_records) finish_run();
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: not all instructions retired");
      fail_run();
    end
  end

  initial begin
    rst_n = 1'b0;
    load_stim();
    cycle_limit = num_records * CYCLES_PER_INSN + RESET_CYCLES + MARGIN;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  end

endmodule

// File: sim/cpu_stim.txt
# M addr data        one memory byte in hex
# E pc a x y z n     expected state at each retire in retire order
# Program at the reset vector
M 0200 A9   # LDA #$00
M 0201 00
M 0202 A2   # LDX #$F0
M 0203 F0
M 0204 A0   # LDY #$05
M 0205 05
M 0206 B5   # LDA $20,X wraps to $10
M 0207 20
M 0208 B6   # LDX $80,Y
M 0209 80
M 020A A4   # LDY $40
M 020B 40
M 020C AD   # LDA $1234
M 020D 34
M 020E 12
M 020F B9   # LDA $30FE,Y crosses a page
M 0210 FE
M 0211 30
M 0212 4C   # JMP $0500
M 0213 00
M 0214 05
# Jump target
M 0500 02   # Unknown opcode
M 0501 A9   # LDA #$45
M 0502 45
M 0503 A9   # LDA #$80
M 0504 80
# Data bytes
M 0010 3C
M 0085 81
M 0040 07
M 1234 7E
M 3105 C4
# Retire records
E 0202 00 00 00 1 0
E 0204 00 F0 00 0 1
E 0206 00 F0 05 0 0   # Z from Y while A is zero
E 0208 3C F0 05 0 0
E 020A 3C 81 05 0 1
E 020C 3C 81 07 0 0
E 020F 7E 81 07 0 0
E 0212 C4 81 07 0 1
E 0500 C4 81 07 0 1   # JMP keeps registers
E 0501 C4 81 07 0 1
E 0503 45 81 07 0 0
E 0505 80 81 07 0 1

// File: tb.f
verilog/cpu_pkg.sv
verilog/isa_pkg.sv
verilog/opcode_decoder.sv
verilog/addr_gen.sv
verilog/reg_file.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_cpu with Verilator, run it and decide from the log
rm -f sim.log
verilator --binary --top-module tb_cpu -f tb.f \
  && ./obj_dir/Vtb_cpu > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
[ -f sim.log ] && cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
